// ==== logic/mrw_consts.svh ====
`ifndef MRW_CONSTS_SVH
`define MRW_CONSTS_SVH

// data word
`define MRW_WIDTH    8

// data banks; the parity bank takes index MRW_NUMVBNK
`define MRW_NUMVBNK  4
`define MRW_BITVBNK  3

// rows per bank
`define MRW_NUMVROW  12
`define MRW_BITVROW  4

// flat address space of NUMVBNK * NUMVROW words
`define MRW_NUMADDR  48
`define MRW_BITADDR  6

// physical address is {bank, row}
`define MRW_BITPADR  7

`endif

// ==== logic/mrw_pkg.sv ====
`default_nettype none

`include "mrw_consts.svh"

package mrw_pkg;

  typedef struct packed {
    logic                     en;
    logic [`MRW_BITADDR-1:0]  addr;
  } rd_req_t;

  typedef struct packed {
    logic                     en;
    logic [`MRW_BITADDR-1:0]  addr;
    logic [`MRW_WIDTH-1:0]    data;
  } wr_req_t;

  // bank 0 to NUMVBNK, parity bank included
  typedef struct packed {
    logic                     en;
    logic [`MRW_BITVBNK-1:0]  bank;
    logic [`MRW_BITVROW-1:0]  row;
  } err_inj_t;

  typedef struct packed {
    logic                     serr;
    logic                     derr;
    logic [`MRW_BITPADR-1:0]  padr;
  } rd_err_t;

  typedef struct packed {
    logic                     vld;
    logic [`MRW_WIDTH-1:0]    data;
    logic                     serr;
    logic                     derr;
    logic [`MRW_BITPADR-1:0]  padr;
  } rd_rsp_t;

  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

// ==== logic/addr_split.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrw_consts.svh"

module addr_split (
  input  wire  [`MRW_BITADDR-1:0] addr,
  output logic [`MRW_BITVBNK-1:0] bank,
  output logic [`MRW_BITVROW-1:0] row
);

  logic [31:0] addr_ext;
  logic [31:0] quot;
  logic [31:0] rem;

  // banks are interleaved, so neighbouring addresses land in different banks
  always_comb begin
    addr_ext = 32'(addr);
    quot     = addr_ext / `MRW_NUMVBNK;
    rem      = addr_ext - quot * `MRW_NUMVBNK;
  end

  assign bank = `MRW_BITVBNK'(rem);
  assign row  = `MRW_BITVROW'(quot);

endmodule

`default_nettype wire

// ==== logic/mem_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrw_consts.svh"

module mem_bank (
  input  wire                     clk,
  input  wire                     rd_en,
  input  wire  [`MRW_BITVROW-1:0] rd_row,
  output logic [`MRW_WIDTH-1:0]   rd_data,
  input  wire                     wr_en,
  input  wire  [`MRW_BITVROW-1:0] wr_row,
  input  wire  [`MRW_WIDTH-1:0]   wr_data
);

  logic [`MRW_WIDTH-1:0] mem [`MRW_NUMVROW];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // read returns the old word when the same row is written on the same edge
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row];
    end
  end

  wr_row_in_range: assert property (@(posedge clk) wr_en |-> wr_row < `MRW_NUMVROW)
    else $error("mem_bank write row %0d out of range", wr_row);

endmodule

`default_nettype wire

// ==== logic/err_track.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrw_consts.svh"

module err_track (
  input  wire                     clk,
  input  wire                     rst,
  input  wire mrw_pkg::err_inj_t  inj,
  input  wire                     clr_en,
  input  wire  [`MRW_BITVBNK-1:0] clr_bank,
  input  wire  [`MRW_BITVROW-1:0] clr_row,
  input  wire                     rd0_en,
  input  wire  [`MRW_BITVBNK-1:0] rd0_bank,
  input  wire  [`MRW_BITVROW-1:0] rd0_row,
  input  wire                     rd1_en,
  input  wire  [`MRW_BITVBNK-1:0] rd1_bank,
  input  wire  [`MRW_BITVROW-1:0] rd1_row,
  input  wire                     rd1_conflict,
  output mrw_pkg::rd_err_t        err0,
  output mrw_pkg::rd_err_t        err1
);

  import mrw_pkg::*;

  // one flag per row and bank with the parity bank in the top bit of each row
  logic [`MRW_NUMVROW-1:0][`MRW_NUMVBNK:0] flag;
  logic [`MRW_BITVBNK-1:0]                 serve1;

  function automatic rd_err_t row_err(input logic [`MRW_NUMVBNK:0]   hits,
                                      input logic [`MRW_BITVBNK-1:0] serve,
                                      input logic [`MRW_BITVROW-1:0] row);
    rd_err_t                 e;
    int                      cnt;
    logic [`MRW_BITVBNK-1:0] low;
    cnt = 0;
    low = serve;
    // walk downwards so the lowest flagged bank is kept
    for (int b = `MRW_NUMVBNK; b >= 0; b--) begin
      if (hits[b]) begin
        cnt = cnt + 1;
        low = `MRW_BITVBNK'(b);
      end
    end
    e.serr = (cnt != 0);
    e.derr = (cnt > 1);
    e.padr = {low, row};
    return e;
  endfunction

  // a rebuilt port 1 word is served by the parity bank
  assign serve1 = rd1_conflict ? `MRW_BITVBNK'(`MRW_NUMVBNK) : rd1_bank;

  always_ff @(posedge clk) begin
    if (rst) begin
      flag <= '0;
    end else begin
      if (clr_en) begin
        flag[clr_row][clr_bank]     <= 1'b0;
        flag[clr_row][`MRW_NUMVBNK] <= 1'b0;
      end
      // injection after the clear so it wins on the same flag
      if (inj.en) begin
        flag[inj.row][inj.bank] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err0 <= '0;
      err1 <= '0;
    end else begin
      if (rd0_en) begin
        err0 <= row_err(flag[rd0_row], rd0_bank, rd0_row);
      end
      if (rd1_en) begin
        err1 <= row_err(flag[rd1_row], serve1, rd1_row);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mrw_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrw_consts.svh"

module mrw_core (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire mrw_pkg::rd_req_t                   rd0,
  input  wire mrw_pkg::rd_req_t                   rd1,
  input  wire mrw_pkg::wr_req_t                   wr,
  input  wire  [`MRW_NUMVBNK:0][`MRW_WIDTH-1:0]   bank_rd_data,
  output logic [`MRW_NUMVBNK:0]                   bank_rd_en,
  output logic [`MRW_NUMVBNK:0][`MRW_BITVROW-1:0] bank_rd_row,
  output logic [`MRW_NUMVBNK:0]                   bank_wr_en,
  output logic [`MRW_NUMVBNK:0][`MRW_BITVROW-1:0] bank_wr_row,
  output logic [`MRW_NUMVBNK:0][`MRW_WIDTH-1:0]   bank_wr_data,
  output logic                                    err_clr_en,
  output logic [`MRW_BITVBNK-1:0]                 err_clr_bank,
  output logic [`MRW_BITVROW-1:0]                 err_clr_row,
  output logic                                    err_rd0_en,
  output logic [`MRW_BITVBNK-1:0]                 err_rd0_bank,
  output logic [`MRW_BITVROW-1:0]                 err_rd0_row,
  output logic                                    err_rd1_en,
  output logic [`MRW_BITVBNK-1:0]                 err_rd1_bank,
  output logic [`MRW_BITVROW-1:0]                 err_rd1_row,
  output logic                                    err_rd1_conflict,
  input  wire mrw_pkg::rd_err_t                   err0,
  input  wire mrw_pkg::rd_err_t                   err1,
  output mrw_pkg::rd_rsp_t                        rsp0,
  output mrw_pkg::rd_rsp_t                        rsp1,
  output logic                                    ready
);

  import mrw_pkg::*;

  init_state_t             state;
  logic [`MRW_BITVROW-1:0] sweep_row;
  logic [`MRW_BITVBNK-1:0] bank0, bank1, wr_bank;
  logic [`MRW_BITVROW-1:0] row0, row1, wr_row;
  logic                    rd0_go, rd1_go, wr_go, conflict;
  logic                    pend_en;
  logic [`MRW_BITVBNK-1:0] pend_bank;
  logic [`MRW_BITVROW-1:0] pend_row;
  logic [`MRW_WIDTH-1:0]   pend_data, par_wr_data;
  logic                    rd0_vld_q, rd1_vld_q, conflict_q, fwd_q;
  logic [`MRW_BITVBNK-1:0] bank0_q, bank1_q;
  logic [`MRW_WIDTH-1:0]   fwd_data_q, rebuild;

  addr_split u_split_rd0 (.addr(rd0.addr), .bank(bank0),   .row(row0));
  addr_split u_split_rd1 (.addr(rd1.addr), .bank(bank1),   .row(row1));
  addr_split u_split_wr  (.addr(wr.addr),  .bank(wr_bank), .row(wr_row));

  // sweep writes zero to one row of every bank per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= INIT_SWEEP;
      sweep_row <= '0;
    end else if (state == INIT_SWEEP) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == `MRW_BITVROW'(`MRW_NUMVROW - 1)) begin
        state <= INIT_DONE;
      end
    end
  end

  assign ready    = (state == INIT_DONE);
  assign rd0_go   = rd0.en && ready;
  assign rd1_go   = rd1.en && ready;
  assign wr_go    = wr.en && ready;
  assign conflict = rd0_go && rd1_go && (bank0 == bank1);

  // new parity is the pending word xor the other banks read on the write edge
  always_comb begin
    par_wr_data = pend_data;
    for (int b = 0; b < `MRW_NUMVBNK; b++) begin
      if (`MRW_BITVBNK'(b) != pend_bank) begin
        par_wr_data = par_wr_data ^ bank_rd_data[b];
      end
    end
  end

  always_comb begin
    bank_rd_en   = '0;
    bank_rd_row  = '0;
    bank_wr_en   = '0;
    bank_wr_row  = '0;
    bank_wr_data = '0;
    for (int b = 0; b < `MRW_NUMVBNK; b++) begin
      if (rd0_go && bank0 == `MRW_BITVBNK'(b)) begin
        bank_rd_en[b]  = 1'b1;
        bank_rd_row[b] = row0;
      end else if (rd1_go) begin
        // own bank, or every other bank when port 1 rebuilds
        if (conflict || bank1 == `MRW_BITVBNK'(b)) begin
          bank_rd_en[b]  = 1'b1;
          bank_rd_row[b] = row1;
        end
      end else if (wr_go && wr_bank != `MRW_BITVBNK'(b)) begin
        bank_rd_en[b]  = 1'b1;
        bank_rd_row[b] = wr_row;
      end
      if (wr_go && wr_bank == `MRW_BITVBNK'(b)) begin
        bank_wr_en[b]   = 1'b1;
        bank_wr_row[b]  = wr_row;
        bank_wr_data[b] = wr.data;
      end
    end
    bank_rd_en[`MRW_NUMVBNK]   = conflict;
    bank_rd_row[`MRW_NUMVBNK]  = row1;
    bank_wr_en[`MRW_NUMVBNK]   = pend_en;
    bank_wr_row[`MRW_NUMVBNK]  = pend_row;
    bank_wr_data[`MRW_NUMVBNK] = par_wr_data;
    if (state == INIT_SWEEP) begin
      bank_wr_en   = '1;
      bank_wr_data = '0;
      for (int b = 0; b <= `MRW_NUMVBNK; b++) begin
        bank_wr_row[b] = sweep_row;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_en    <= 1'b0;
      rd0_vld_q  <= 1'b0;
      rd1_vld_q  <= 1'b0;
      conflict_q <= 1'b0;
      fwd_q      <= 1'b0;
    end else begin
      pend_en    <= wr_go;
      rd0_vld_q  <= rd0_go;
      rd1_vld_q  <= rd1_go;
      conflict_q <= conflict;
      // the parity row is still being written on this edge so the bank returns the old value
      fwd_q      <= conflict && pend_en && (row1 == pend_row);
    end
  end

  always_ff @(posedge clk) begin
    pend_bank  <= wr_bank;
    pend_row   <= wr_row;
    pend_data  <= wr.data;
    bank0_q    <= bank0;
    bank1_q    <= bank1;
    fwd_data_q <= par_wr_data;
  end

  always_comb begin
    rebuild = fwd_q ? fwd_data_q : bank_rd_data[`MRW_NUMVBNK];
    for (int b = 0; b < `MRW_NUMVBNK; b++) begin
      if (`MRW_BITVBNK'(b) != bank1_q) begin
        rebuild = rebuild ^ bank_rd_data[b];
      end
    end
  end

  always_comb begin
    rsp0.vld  = rd0_vld_q;
    rsp0.data = bank_rd_data[bank0_q];
    rsp0.serr = err0.serr;
    rsp0.derr = err0.derr;
    rsp0.padr = err0.padr;
    rsp1.vld  = rd1_vld_q;
    rsp1.data = conflict_q ? rebuild : bank_rd_data[bank1_q];
    rsp1.serr = err1.serr;
    rsp1.derr = err1.derr;
    rsp1.padr = err1.padr;
  end

  assign err_clr_en       = wr_go;
  assign err_clr_bank     = wr_bank;
  assign err_clr_row      = wr_row;
  assign err_rd0_en       = rd0_go;
  assign err_rd0_bank     = bank0;
  assign err_rd0_row      = row0;
  assign err_rd1_en       = rd1_go;
  assign err_rd1_bank     = bank1;
  assign err_rd1_row      = row1;
  assign err_rd1_conflict = conflict;

  no_read_with_write: assert property (@(posedge clk) disable iff (rst)
    wr.en |-> !(rd0.en || rd1.en))
    else $error("read and write requested in the same cycle");

  no_req_before_ready: assert property (@(posedge clk) disable iff (rst)
    !ready |-> !(rd0.en || rd1.en || wr.en))
    else $error("request while the reset sweep is running");

endmodule

`default_nettype wire

// ==== logic/mrw_2ror1w.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrw_consts.svh"

module mrw_2ror1w (
  input  wire                    clk,
  input  wire                    rst,
  input  wire mrw_pkg::rd_req_t  rd0,
  input  wire mrw_pkg::rd_req_t  rd1,
  input  wire mrw_pkg::wr_req_t  wr,
  input  wire mrw_pkg::err_inj_t inj,
  output mrw_pkg::rd_rsp_t       rsp0,
  output mrw_pkg::rd_rsp_t       rsp1,
  output logic                   ready
);

  import mrw_pkg::*;

  // data banks 0 to NUMVBNK-1, parity bank at NUMVBNK
  logic [`MRW_NUMVBNK:0]                   bank_rd_en;
  logic [`MRW_NUMVBNK:0][`MRW_BITVROW-1:0] bank_rd_row;
  logic [`MRW_NUMVBNK:0][`MRW_WIDTH-1:0]   bank_rd_data;
  logic [`MRW_NUMVBNK:0]                   bank_wr_en;
  logic [`MRW_NUMVBNK:0][`MRW_BITVROW-1:0] bank_wr_row;
  logic [`MRW_NUMVBNK:0][`MRW_WIDTH-1:0]   bank_wr_data;

  logic                    clr_en;
  logic [`MRW_BITVBNK-1:0] clr_bank;
  logic [`MRW_BITVROW-1:0] clr_row;
  logic                    rd0_en, rd1_en, rd1_conflict;
  logic [`MRW_BITVBNK-1:0] rd0_bank, rd1_bank;
  logic [`MRW_BITVROW-1:0] rd0_row, rd1_row;
  rd_err_t                 err0, err1;

  mrw_core u_core (
    .clk              (clk),
    .rst              (rst),
    .rd0              (rd0),
    .rd1              (rd1),
    .wr               (wr),
    .bank_rd_data     (bank_rd_data),
    .bank_rd_en       (bank_rd_en),
    .bank_rd_row      (bank_rd_row),
    .bank_wr_en       (bank_wr_en),
    .bank_wr_row      (bank_wr_row),
    .bank_wr_data     (bank_wr_data),
    .err_clr_en       (clr_en),
    .err_clr_bank     (clr_bank),
    .err_clr_row      (clr_row),
    .err_rd0_en       (rd0_en),
    .err_rd0_bank     (rd0_bank),
    .err_rd0_row      (rd0_row),
    .err_rd1_en       (rd1_en),
    .err_rd1_bank     (rd1_bank),
    .err_rd1_row      (rd1_row),
    .err_rd1_conflict (rd1_conflict),
    .err0             (err0),
    .err1             (err1),
    .rsp0             (rsp0),
    .rsp1             (rsp1),
    .ready            (ready)
  );

  err_track u_err (
    .clk          (clk),
    .rst          (rst),
    .inj          (inj),
    .clr_en       (clr_en),
    .clr_bank     (clr_bank),
    .clr_row      (clr_row),
    .rd0_en       (rd0_en),
    .rd0_bank     (rd0_bank),
    .rd0_row      (rd0_row),
    .rd1_en       (rd1_en),
    .rd1_bank     (rd1_bank),
    .rd1_row      (rd1_row),
    .rd1_conflict (rd1_conflict),
    .err0         (err0),
    .err1         (err1)
  );

  for (genvar b = 0; b <= `MRW_NUMVBNK; b++) begin : g_bank
    mem_bank u_bank (
      .clk     (clk),
      .rd_en   (bank_rd_en[b]),
      .rd_row  (bank_rd_row[b]),
      .rd_data (bank_rd_data[b]),
      .wr_en   (bank_wr_en[b]),
      .wr_row  (bank_wr_row[b]),
      .wr_data (bank_wr_data[b])
    );
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_mrw_2ror1w.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrw_consts.svh"

module tb_mrw_2ror1w;

  import mrw_pkg::*;

  localparam int NUMVBNK = `MRW_NUMVBNK;
  localparam int NUMVROW = `MRW_NUMVROW;
  localparam int NUMADDR = `MRW_NUMADDR;
  // the tests take about 1100 cycles
  localparam int MAX_CYCLES = 2000;

  logic     clk;
  logic     rst;
  rd_req_t  rd0, rd1;
  wr_req_t  wr;
  err_inj_t inj;
  rd_rsp_t  rsp0, rsp1;
  logic     ready;

  // reference model of the words and the error flags
  logic [`MRW_WIDTH-1:0] mem_model [NUMADDR];
  bit   [NUMVBNK:0]      flags [NUMVROW];

  // exp0 and exp1 go with the requests being driven and the _chk copies with those under check
  rd_rsp_t exp0, exp1, exp0_chk, exp1_chk, got0, got1;
  bit      chk0, chk1, got_ready, ready_seen;
  string   test_name, chk_name;
  int      err_cnt = 0;
  int      check_cnt = 0;
  int      cycle_cnt = 0;

  tb_clock u_clock (.clk(clk));

  mrw_2ror1w UUT (
    .clk   (clk),
    .rst   (rst),
    .rd0   (rd0),
    .rd1   (rd1),
    .wr    (wr),
    .inj   (inj),
    .rsp0  (rsp0),
    .rsp1  (rsp1),
    .ready (ready)
  );

  function automatic int addr_of(input int bank, input int row);
    return row * NUMVBNK + bank;
  endfunction

  function automatic int rand_addr();
    return int'($urandom % NUMADDR);
  endfunction

  function automatic int rand_row();
    return int'($urandom % NUMVROW);
  endfunction

  function automatic int rand_bank();
    return int'($urandom % NUMVBNK);
  endfunction

  // padr names the first flagged bank of the row, else the serving bank
  function automatic rd_rsp_t expect_rsp(input int addr, input bit rebuilt);
    rd_rsp_t r;
    int      row;
    int      hits;
    int      first;
    row   = addr / NUMVBNK;
    hits  = 0;
    first = rebuilt ? NUMVBNK : addr % NUMVBNK;
    for (int b = 0; b <= NUMVBNK; b++) begin
      if (flags[row][b]) begin
        if (hits == 0) begin
          first = b;
        end
        hits++;
      end
    end
    r.vld  = 1'b1;
    r.data = mem_model[addr];
    r.serr = (hits > 0);
    r.derr = (hits > 1);
    r.padr = {`MRW_BITVBNK'(first), `MRW_BITVROW'(row)};
    return r;
  endfunction

  function automatic string rsp_text(input rd_rsp_t r);
    return $sformatf("vld=%b data=%h serr=%b derr=%b padr=%h",
                     r.vld, r.data, r.serr, r.derr, r.padr);
  endfunction

  task automatic report_fail(input string name, input string what,
                             input string expected, input string actual);
    err_cnt++;
    $display("CHECK FAILED %s %s expected %s actual %s", name, what, expected, actual);
  endtask

  task automatic finish_run(input bit timed_out);
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // the response of a request sampled at this edge is already on rsp0 and rsp1
  task automatic tick();
    @(posedge clk);
    #1;
    chk0      = rd0.en;
    chk1      = rd1.en;
    exp0_chk  = exp0;
    exp1_chk  = exp1;
    got0      = rsp0;
    got1      = rsp1;
    got_ready = ready;
    chk_name  = test_name;
    check_cnt = check_cnt + int'(chk0) + int'(chk1);
    rd0       = '0;
    rd1       = '0;
    wr        = '0;
    inj       = '0;
  endtask

  task automatic read_pair(input int a0, input int a1);
    rd0.en   = 1'b1;
    rd0.addr = `MRW_BITADDR'(a0);
    rd1.en   = 1'b1;
    rd1.addr = `MRW_BITADDR'(a1);
    exp0     = expect_rsp(a0, 1'b0);
    exp1     = expect_rsp(a1, (a0 % NUMVBNK) == (a1 % NUMVBNK));
    tick();
  endtask

  task automatic write_word(input int addr, input logic [`MRW_WIDTH-1:0] data);
    wr.en                         = 1'b1;
    wr.addr                       = `MRW_BITADDR'(addr);
    wr.data                       = data;
    mem_model[addr]               = data;
    flags[addr / NUMVBNK][addr % NUMVBNK] = 1'b0;
    flags[addr / NUMVBNK][NUMVBNK]        = 1'b0;
    tick();
  endtask

  task automatic inject_flag(input int bank, input int row);
    inj.en          = 1'b1;
    inj.bank        = `MRW_BITVBNK'(bank);
    inj.row         = `MRW_BITVROW'(row);
    flags[row][bank] = 1'b1;
    tick();
  endtask

  rsp0_check: assert property (@(posedge clk) disable iff (rst) chk0 |-> got0 == exp0_chk)
    else report_fail(chk_name, "port 0", rsp_text(exp0_chk), rsp_text(got0));

  rsp1_check: assert property (@(posedge clk) disable iff (rst) chk1 |-> got1 == exp1_chk)
    else report_fail(chk_name, "port 1", rsp_text(exp1_chk), rsp_text(got1));

  valid_check: assert property (@(posedge clk) disable iff (rst)
    {got0.vld, got1.vld} == {chk0, chk1})
    else report_fail(chk_name, "valids", $sformatf("%b%b", chk0, chk1),
                     $sformatf("%b%b", got0.vld, got1.vld));

  ready_hold: assert property (@(posedge clk) disable iff (rst) ready_seen |-> got_ready)
    else report_fail(chk_name, "ready", "1", "0");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  initial begin
    int sweep_cycles;
    int a0;
    int bank;
    int bank2;
    int row;
    void'($urandom(45));
    rst        = 1'b1;
    rd0        = '0;
    rd1        = '0;
    wr         = '0;
    inj        = '0;
    exp0       = '0;
    exp1       = '0;
    got0       = '0;
    got1       = '0;
    got_ready  = 1'b0;
    ready_seen = 1'b0;
    test_name  = "reset";
    foreach (mem_model[i]) mem_model[i] = '0;
    foreach (flags[i]) flags[i] = '0;
    repeat (3) tick();
    rst = 1'b0;

    test_name    = "reset sweep";
    sweep_cycles = 0;
    while (!got_ready) begin
      tick();
      sweep_cycles++;
    end
    sweep_len: assert (sweep_cycles == NUMVROW)
      else report_fail(test_name, "ready delay", $sformatf("%0d", NUMVROW),
                       $sformatf("%0d", sweep_cycles));
    ready_seen = 1'b1;

    test_name = "zero after sweep";
    for (int a = 0; a < NUMADDR; a += 2) begin
      read_pair(a, a + 1);
    end

    test_name = "write then read";
    for (int a = 0; a < NUMADDR; a++) begin
      write_word(a, `MRW_WIDTH'($urandom));
    end
    repeat (150) begin
      write_word(rand_addr(), `MRW_WIDTH'($urandom));
      a0   = rand_addr();
      bank = (a0 + 1 + int'($urandom % (NUMVBNK - 1))) % NUMVBNK;
      read_pair(a0, addr_of(bank, rand_row()));
    end

    test_name = "same bank reads";
    repeat (200) begin
      a0 = rand_addr();
      read_pair(a0, addr_of(a0 % NUMVBNK, rand_row()));
    end

    // port 1 rebuilds the row whose parity is still pending
    test_name = "read after write";
    repeat (100) begin
      a0 = rand_addr();
      write_word(a0, `MRW_WIDTH'($urandom));
      bank = rand_bank();
      read_pair(addr_of(bank, rand_row()), addr_of(bank, a0 / NUMVBNK));
    end

    test_name = "single error";
    repeat (20) begin
      bank = int'($urandom % (NUMVBNK + 1));
      row  = rand_row();
      inject_flag(bank, row);
      a0 = addr_of(rand_bank(), row);
      read_pair(a0, addr_of(a0 % NUMVBNK, row));
      read_pair(a0, addr_of((a0 + 1) % NUMVBNK, row));
      // bank 0 when the parity bank was flagged
      write_word(addr_of(bank % NUMVBNK, row), `MRW_WIDTH'($urandom));
      read_pair(a0, addr_of(a0 % NUMVBNK, row));
    end

    test_name = "multiple errors";
    repeat (20) begin
      row   = rand_row();
      bank  = int'($urandom % (NUMVBNK + 1));
      bank2 = (bank + 1 + int'($urandom % NUMVBNK)) % (NUMVBNK + 1);
      inject_flag(bank, row);
      inject_flag(bank2, row);
      a0 = addr_of(rand_bank(), row);
      read_pair(a0, addr_of(rand_bank(), row));
      write_word(addr_of(rand_bank(), row), `MRW_WIDTH'($urandom));
      read_pair(a0, addr_of(rand_bank(), row));
      for (int b = 0; b < NUMVBNK; b++) begin
        write_word(addr_of(b, row), `MRW_WIDTH'($urandom));
      end
      read_pair(a0, addr_of(rand_bank(), row));
    end

    tick();
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

// ==== mrw_2ror1w.f ====
+incdir+logic
logic/mrw_pkg.sv
logic/addr_split.sv
logic/mem_bank.sv
logic/err_track.sv
logic/mrw_core.sv
logic/mrw_2ror1w.sv
testbench/tb_clock.sv
testbench/tb_mrw_2ror1w.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mrw_2ror1w
FILELIST  := mrw_2ror1w.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := NO ERRORS

SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
